// ==== source/exu_pkg.sv ====
package exu_pkg;

   // datapath width
   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   // alu opcodes, 6-bit field from decode
   typedef enum logic [5:0] {
      alu_add    = 6'd0,
      alu_sub    = 6'd1,
      alu_and    = 6'd2,
      alu_or     = 6'd3,
      alu_xor    = 6'd4,
      alu_nor    = 6'd5,
      alu_slt    = 6'd6,
      alu_sltu   = 6'd7,
      alu_sll    = 6'd8,
      alu_srl    = 6'd9,
      alu_sra    = 6'd10,
      alu_pass_b = 6'd11
   } alu_op_t;

   // branch opcodes, 4-bit field from decode
   typedef enum logic [3:0] {
      bru_beq  = 4'd0,
      bru_bne  = 4'd1,
      bru_blt  = 4'd2,
      bru_bge  = 4'd3,
      bru_bltu = 4'd4,
      bru_bgeu = 4'd5,
      bru_b    = 4'd6,
      bru_bl   = 4'd7,
      bru_jirl = 4'd8
   } bru_op_t;

   // link address is the next sequential instruction
   localparam word_t link_offset = 32'd4;

endpackage

// ==== source/exu_regfile.sv ====
`timescale 1ns/10ps

module exu_regfile #(
   parameter int reg_count = 32
) (
   input  logic              clk,
   input  logic              rst_n,
   input  exu_pkg::reg_addr_t raddr1,
   input  exu_pkg::reg_addr_t raddr2,
   output exu_pkg::word_t    rdata1,
   output exu_pkg::word_t    rdata2,
   input  logic              wen,
   input  exu_pkg::reg_addr_t waddr,
   input  exu_pkg::word_t    wdata
);

   import exu_pkg::*;

   localparam int idx_w = $clog2(reg_count);

   word_t regs [reg_count];

   // one read port, with write-through from W
   function automatic word_t read_port(input reg_addr_t addr);
      logic [idx_w-1:0] idx;
      idx = addr[idx_w-1:0];
      if (idx == '0)
         return '0;
      else if (wen && waddr[idx_w-1:0] == idx)
         return wdata;
      else
         return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++)
            regs[i] <= '0;
      end else if (wen && waddr[idx_w-1:0] != '0) begin
         regs[waddr[idx_w-1:0]] <= wdata;
      end
   end

   always_comb begin
      rdata1 = read_port(raddr1);
      rdata2 = read_port(raddr2);
   end

endmodule

// ==== source/exu_bypass.sv ====
`timescale 1ns/10ps

module exu_bypass (
   input  exu_pkg::reg_addr_t rs1_e,
   input  exu_pkg::reg_addr_t rs2_e,
   input  exu_pkg::word_t     rs1_data_e,
   input  exu_pkg::word_t     rs2_data_e,
   input  logic               wen_m,
   input  exu_pkg::reg_addr_t rd_m,
   input  exu_pkg::word_t     rd_data_m,
   input  logic               wen_w,
   input  exu_pkg::reg_addr_t rd_w,
   input  exu_pkg::word_t     rd_data_w,
   output exu_pkg::word_t     rs1_fwd,
   output exu_pkg::word_t     rs2_fwd
);

   import exu_pkg::*;

   // youngest producer wins, r0 never forwarded
   function automatic word_t fwd(input reg_addr_t rs, input word_t rf_data);
      if (rs != '0 && wen_m && rd_m == rs)
         return rd_data_m;
      else if (rs != '0 && wen_w && rd_w == rs)
         return rd_data_w;
      else
         return rf_data;
   endfunction

   always_comb begin
      rs1_fwd = fwd(rs1_e, rs1_data_e);
      rs2_fwd = fwd(rs2_e, rs2_data_e);
   end

endmodule

// ==== source/exu_alu.sv ====
`timescale 1ns/10ps

module exu_alu (
   input  exu_pkg::alu_op_t op,
   input  exu_pkg::word_t   a,
   input  exu_pkg::word_t   b,
   output exu_pkg::word_t   result
);

   import exu_pkg::*;

   logic [4:0] shamt;

   // only low five bits shift
   assign shamt = b[4:0];

   always_comb begin
      case (op)
         alu_add: begin
            result = a + b;
         end
         alu_sub: begin
            result = a - b;
         end
         alu_and: begin
            result = a & b;
         end
         alu_or: begin
            result = a | b;
         end
         alu_xor: begin
            result = a ^ b;
         end
         alu_nor: begin
            result = ~(a | b);
         end
         alu_slt: begin
            result = word_t'($signed(a) < $signed(b));
         end
         alu_sltu: begin
            result = word_t'(a < b);
         end
         alu_sll: begin
            result = a << shamt;
         end
         alu_srl: begin
            result = a >> shamt;
         end
         alu_sra: begin
            result = word_t'($signed(a) >>> shamt);
         end
         // immediate loads come through b
         alu_pass_b: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// ==== source/exu_branch.sv ====
`timescale 1ns/10ps

module exu_branch (
   input  logic             vld,
   input  exu_pkg::bru_op_t op,
   input  exu_pkg::word_t   a,
   input  exu_pkg::word_t   b,
   input  exu_pkg::word_t   pc,
   input  exu_pkg::word_t   offset,
   output logic             taken,
   output exu_pkg::word_t   target,
   output exu_pkg::word_t   link
);

   import exu_pkg::*;

   logic  cond;
   word_t base;

   always_comb begin
      case (op)
         bru_beq:  cond = (a == b);
         bru_bne:  cond = (a != b);
         bru_blt:  cond = ($signed(a) < $signed(b));
         bru_bge:  cond = ($signed(a) >= $signed(b));
         bru_bltu: cond = (a < b);
         bru_bgeu: cond = (a >= b);
         // unconditional forms
         bru_b:    cond = 1'b1;
         bru_bl:   cond = 1'b1;
         bru_jirl: cond = 1'b1;
         default:  cond = 1'b0;
      endcase
   end

   assign taken = vld & cond;

   // jirl is register indirect, others pc relative
   assign base   = (op == bru_jirl) ? a : pc;
   assign target = base + offset;
   assign link   = pc + link_offset;

endmodule

// ==== source/exu_pipe.sv ====
`timescale 1ns/10ps

module exu_pipe (
   input  logic               clk,
   input  logic               rst_n,
   // issue, D stage
   input  logic               issue_vld,
   input  exu_pkg::word_t     issue_pc,
   input  exu_pkg::reg_addr_t rs1,
   input  exu_pkg::reg_addr_t rs2,
   input  exu_pkg::reg_addr_t rd,
   input  logic               wen,
   input  exu_pkg::word_t     imm,
   input  logic               alu_vld,
   input  exu_pkg::alu_op_t   alu_op,
   input  logic               alu_a_pc,
   input  logic               alu_b_imm,
   input  logic               bru_vld,
   input  exu_pkg::bru_op_t   bru_op,
   input  exu_pkg::word_t     bru_offset,
   input  exu_pkg::word_t     rs1_data_d,
   input  exu_pkg::word_t     rs2_data_d,
   // E stage
   output exu_pkg::reg_addr_t rs1_e,
   output exu_pkg::reg_addr_t rs2_e,
   output exu_pkg::word_t     rs1_data_e,
   output exu_pkg::word_t     rs2_data_e,
   input  exu_pkg::word_t     rs1_fwd,
   input  exu_pkg::word_t     rs2_fwd,
   output exu_pkg::alu_op_t   alu_op_e,
   output exu_pkg::word_t     alu_a,
   output exu_pkg::word_t     alu_b,
   input  exu_pkg::word_t     alu_res,
   output logic               bru_vld_e,
   output exu_pkg::bru_op_t   bru_op_e,
   output exu_pkg::word_t     pc_e,
   output exu_pkg::word_t     bru_offset_e,
   input  logic               bru_taken,
   input  exu_pkg::word_t     bru_target,
   input  exu_pkg::word_t     bru_link,
   // M stage
   output logic               wen_m,
   output exu_pkg::reg_addr_t rd_m,
   output exu_pkg::word_t     rd_data_m,
   // W stage
   output logic               wen_w,
   output exu_pkg::reg_addr_t rd_w,
   output exu_pkg::word_t     rd_data_w,
   output exu_pkg::word_t     commit_pc,
   output logic               branch,
   output exu_pkg::word_t     brn_addr
);

   import exu_pkg::*;

   logic      flush;
   logic      wen_e;
   logic      alu_vld_e;
   reg_addr_t rd_e;
   word_t     imm_e;
   logic      alu_a_pc_e;
   logic      alu_b_imm_e;

   logic      alu_vld_m;
   logic      bru_vld_m;
   logic      branch_m;
   word_t     pc_m;
   word_t     alu_res_m;
   word_t     link_m;
   word_t     brn_addr_m;

   // taken branch anywhere in E..W kills the issue slot
   assign flush = bru_taken | branch_m | branch;

   // stage valids and write enables
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wen_e     <= 1'b0;
         alu_vld_e <= 1'b0;
         bru_vld_e <= 1'b0;
         wen_m     <= 1'b0;
         alu_vld_m <= 1'b0;
         bru_vld_m <= 1'b0;
         branch_m  <= 1'b0;
         wen_w     <= 1'b0;
         branch    <= 1'b0;
      end else begin
         wen_e     <= issue_vld & wen & ~flush;
         alu_vld_e <= issue_vld & alu_vld & ~flush;
         bru_vld_e <= issue_vld & bru_vld & ~flush;
         wen_m     <= wen_e;
         alu_vld_m <= alu_vld_e;
         bru_vld_m <= bru_vld_e;
         branch_m  <= bru_taken;
         wen_w     <= wen_m;
         branch    <= branch_m;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      pc_e         <= issue_pc;
      rs1_e        <= rs1;
      rs2_e        <= rs2;
      rs1_data_e   <= rs1_data_d;
      rs2_data_e   <= rs2_data_d;
      rd_e         <= rd;
      imm_e        <= imm;
      alu_op_e     <= alu_op;
      alu_a_pc_e   <= alu_a_pc;
      alu_b_imm_e  <= alu_b_imm;
      bru_op_e     <= bru_op;
      bru_offset_e <= bru_offset;

      pc_m         <= pc_e;
      rd_m         <= rd_e;
      alu_res_m    <= alu_res;
      link_m       <= bru_link;
      brn_addr_m   <= bru_target;

      commit_pc    <= pc_m;
      rd_w         <= rd_m;
      rd_data_w    <= rd_data_m;
      brn_addr     <= brn_addr_m;
   end

   // operand select for the alu
   assign alu_a = alu_a_pc_e ? pc_e : rs1_fwd;
   assign alu_b = alu_b_imm_e ? imm_e : rs2_fwd;

   // one unit valid at a time, so an and-or merge is enough
   assign rd_data_m = ({xlen{alu_vld_m}} & alu_res_m) |
                      ({xlen{bru_vld_m}} & link_m);

endmodule

// ==== source/exu_top.sv ====
`timescale 1ns/10ps

module exu_top #(
   parameter int reg_count = 32
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               issue_vld,
   input  exu_pkg::word_t     issue_pc,
   input  exu_pkg::reg_addr_t rs1,
   input  exu_pkg::reg_addr_t rs2,
   input  exu_pkg::reg_addr_t rd,
   input  logic               wen,
   input  exu_pkg::word_t     imm,
   input  logic               alu_vld,
   input  exu_pkg::alu_op_t   alu_op,
   input  logic               alu_a_pc,
   input  logic               alu_b_imm,
   input  logic               bru_vld,
   input  exu_pkg::bru_op_t   bru_op,
   input  exu_pkg::word_t     bru_offset,
   output logic               commit_vld,
   output exu_pkg::reg_addr_t commit_rd,
   output exu_pkg::word_t     commit_data,
   output exu_pkg::word_t     commit_pc,
   output logic               branch,
   output exu_pkg::word_t     brn_addr
);

   import exu_pkg::*;

   word_t     rs1_data_d;
   word_t     rs2_data_d;
   reg_addr_t rs1_e;
   reg_addr_t rs2_e;
   word_t     rs1_data_e;
   word_t     rs2_data_e;
   word_t     rs1_fwd;
   word_t     rs2_fwd;
   alu_op_t   alu_op_e;
   word_t     alu_a;
   word_t     alu_b;
   word_t     alu_res;
   logic      bru_vld_e;
   bru_op_t   bru_op_e;
   word_t     pc_e;
   word_t     bru_offset_e;
   logic      bru_taken;
   word_t     bru_target;
   word_t     bru_link;
   logic      wen_m;
   reg_addr_t rd_m;
   word_t     rd_data_m;

   exu_regfile #(
      .reg_count (reg_count)
   ) u_rf (
      .clk    (clk),
      .rst_n  (rst_n),
      .raddr1 (rs1),
      .raddr2 (rs2),
      .rdata1 (rs1_data_d),
      .rdata2 (rs2_data_d),
      .wen    (commit_vld),
      .waddr  (commit_rd),
      .wdata  (commit_data)
   );

   exu_bypass u_byp (
      .rs1_e      (rs1_e),
      .rs2_e      (rs2_e),
      .rs1_data_e (rs1_data_e),
      .rs2_data_e (rs2_data_e),
      .wen_m      (wen_m),
      .rd_m       (rd_m),
      .rd_data_m  (rd_data_m),
      .wen_w      (commit_vld),
      .rd_w       (commit_rd),
      .rd_data_w  (commit_data),
      .rs1_fwd    (rs1_fwd),
      .rs2_fwd    (rs2_fwd)
   );

   exu_alu u_alu (
      .op     (alu_op_e),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_res)
   );

   exu_branch u_bru (
      .vld    (bru_vld_e),
      .op     (bru_op_e),
      .a      (rs1_fwd),
      .b      (rs2_fwd),
      .pc     (pc_e),
      .offset (bru_offset_e),
      .taken  (bru_taken),
      .target (bru_target),
      .link   (bru_link)
   );

   // W-stage write port doubles as the commit port
   exu_pipe u_pipe (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_vld    (issue_vld),
      .issue_pc     (issue_pc),
      .rs1          (rs1),
      .rs2          (rs2),
      .rd           (rd),
      .wen          (wen),
      .imm          (imm),
      .alu_vld      (alu_vld),
      .alu_op       (alu_op),
      .alu_a_pc     (alu_a_pc),
      .alu_b_imm    (alu_b_imm),
      .bru_vld      (bru_vld),
      .bru_op       (bru_op),
      .bru_offset   (bru_offset),
      .rs1_data_d   (rs1_data_d),
      .rs2_data_d   (rs2_data_d),
      .rs1_e        (rs1_e),
      .rs2_e        (rs2_e),
      .rs1_data_e   (rs1_data_e),
      .rs2_data_e   (rs2_data_e),
      .rs1_fwd      (rs1_fwd),
      .rs2_fwd      (rs2_fwd),
      .alu_op_e     (alu_op_e),
      .alu_a        (alu_a),
      .alu_b        (alu_b),
      .alu_res      (alu_res),
      .bru_vld_e    (bru_vld_e),
      .bru_op_e     (bru_op_e),
      .pc_e         (pc_e),
      .bru_offset_e (bru_offset_e),
      .bru_taken    (bru_taken),
      .bru_target   (bru_target),
      .bru_link     (bru_link),
      .wen_m        (wen_m),
      .rd_m         (rd_m),
      .rd_data_m    (rd_data_m),
      .wen_w        (commit_vld),
      .rd_w         (commit_rd),
      .rd_data_w    (commit_data),
      .commit_pc    (commit_pc),
      .branch       (branch),
      .brn_addr     (brn_addr)
   );

endmodule

// ==== sim/exu_tb.sv ====
`timescale 1ns/10ps

module exu_tb;

   import exu_pkg::*;

   localparam int reg_count   = 32;
   localparam int drain_limit = 40;
   localparam int run_limit   = 20000;

   logic      clk;
   logic      rst_n;
   logic      issue_vld;
   word_t     issue_pc;
   reg_addr_t rs1;
   reg_addr_t rs2;
   reg_addr_t rd;
   logic      wen;
   word_t     imm;
   logic      alu_vld;
   alu_op_t   alu_op;
   logic      alu_a_pc;
   logic      alu_b_imm;
   logic      bru_vld;
   bru_op_t   bru_op;
   word_t     bru_offset;
   logic      commit_vld;
   reg_addr_t commit_rd;
   word_t     commit_data;
   word_t     commit_pc;
   logic      branch;
   word_t     brn_addr;

   // reference state
   word_t       shadow [32];
   int          flush_cnt;
   word_t       pc_next;
   logic [31:0] lfsr;
   int          cyc = 0;
   string       test_name;
   int          checks;
   int          errors;
   int          test_checks;
   int          test_errors;
   int          ntests;

   // expected W-stage events in issue order
   int        exp_cyc    [$];
   logic      exp_commit [$];
   reg_addr_t exp_rd     [$];
   word_t     exp_data   [$];
   word_t     exp_pc     [$];
   logic      exp_branch [$];
   word_t     exp_target [$];

   always #20 clk = ~clk;

   exu_top #(
      .reg_count (reg_count)
   ) i_exu_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_vld   (issue_vld),
      .issue_pc    (issue_pc),
      .rs1         (rs1),
      .rs2         (rs2),
      .rd          (rd),
      .wen         (wen),
      .imm         (imm),
      .alu_vld     (alu_vld),
      .alu_op      (alu_op),
      .alu_a_pc    (alu_a_pc),
      .alu_b_imm   (alu_b_imm),
      .bru_vld     (bru_vld),
      .bru_op      (bru_op),
      .bru_offset  (bru_offset),
      .commit_vld  (commit_vld),
      .commit_rd   (commit_rd),
      .commit_data (commit_data),
      .commit_pc   (commit_pc),
      .branch      (branch),
      .brn_addr    (brn_addr)
   );

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic reg_addr_t rand_src();
      return 5'(take_bits(4));
   endfunction

   function automatic alu_op_t rand_alu_op();
      return alu_op_t'(6'(take_bits(4) % 12));
   endfunction

   // expected alu result
   function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
      logic signed [31:0] sa;
      sa = a;
      case (op)
         alu_add:  return a + b;
         alu_sub:  return a - b;
         alu_and:  return a & b;
         alu_or:   return a | b;
         alu_xor:  return a ^ b;
         alu_nor:  return ~(a | b);
         alu_slt:  return (sa < $signed(b)) ? 32'd1 : 32'd0;
         alu_sltu: return (a < b) ? 32'd1 : 32'd0;
         alu_sll:  return a << b[4:0];
         alu_srl:  return a >> b[4:0];
         alu_sra:  return sa >>> b[4:0];
         default:  return b;
      endcase
   endfunction

   // expected branch decision
   function automatic logic ref_taken(input bru_op_t op, input word_t a, input word_t b);
      case (op)
         bru_beq:  return a == b;
         bru_bne:  return a != b;
         bru_blt:  return $signed(a) < $signed(b);
         bru_bge:  return $signed(a) >= $signed(b);
         bru_bltu: return a < b;
         bru_bgeu: return a >= b;
         default:  return 1'b1;
      endcase
   endfunction

   task automatic compare_word(input string what, input word_t exp, input word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      end
   endtask

   task automatic compare_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s %s: expected r%0d, actual r%0d", test_name, what, exp, act);
      end
   endtask

   task automatic compare_flag(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $finish;
   endtask

   // shadow file tracks results in program order
   task automatic model_slot(input logic vld, input logic is_alu, input alu_op_t aop,
                             input bru_op_t bop, input reg_addr_t s1, input reg_addr_t s2,
                             input reg_addr_t d, input logic w, input logic a_pc,
                             input logic b_imm, input word_t immv, input word_t off,
                             input word_t pc);
      word_t a;
      word_t b;
      word_t data;
      word_t tgt;
      logic  taken;
      if (flush_cnt > 0) begin
         flush_cnt--;
      end else if (vld) begin
         a     = shadow[s1];
         b     = shadow[s2];
         taken = 1'b0;
         tgt   = '0;
         if (is_alu) begin
            data = ref_alu(aop, a_pc ? pc : a, b_imm ? immv : b);
         end else begin
            data  = pc + 32'd4;
            taken = ref_taken(bop, a, b);
            tgt   = ((bop == bru_jirl) ? a : pc) + off;
         end
         if (w && d != 5'd0)
            shadow[d] = data;
         if (w || taken) begin
            exp_cyc.push_back(cyc + 4);
            exp_commit.push_back(w);
            exp_rd.push_back(d);
            exp_data.push_back(data);
            exp_pc.push_back(pc);
            exp_branch.push_back(taken);
            exp_target.push_back(tgt);
         end
         // three younger slots are discarded
         if (taken)
            flush_cnt = 3;
      end
   endtask

   task automatic send(input logic vld, input logic is_alu, input alu_op_t aop,
                       input bru_op_t bop, input reg_addr_t s1, input reg_addr_t s2,
                       input reg_addr_t d, input logic w, input logic a_pc,
                       input logic b_imm, input word_t immv, input word_t off);
      @(posedge clk);
      issue_vld  <= vld;
      issue_pc   <= pc_next;
      rs1        <= s1;
      rs2        <= s2;
      rd         <= d;
      wen        <= w;
      imm        <= immv;
      alu_vld    <= vld & is_alu;
      alu_op     <= aop;
      alu_a_pc   <= a_pc;
      alu_b_imm  <= b_imm;
      bru_vld    <= vld & ~is_alu;
      bru_op     <= bop;
      bru_offset <= off;
      model_slot(vld, is_alu, aop, bop, s1, s2, d, w, a_pc, b_imm, immv, off, pc_next);
      if (vld)
         pc_next = pc_next + 32'd4;
   endtask

   task automatic idle();
      send(1'b0, 1'b1, alu_add, bru_beq, '0, '0, '0, 1'b0, 1'b0, 1'b0, '0, '0);
   endtask

   task automatic alu_rr(input alu_op_t op, input reg_addr_t d, input reg_addr_t s1,
                         input reg_addr_t s2);
      send(1'b1, 1'b1, op, bru_beq, s1, s2, d, 1'b1, 1'b0, 1'b0, '0, '0);
   endtask

   task automatic alu_ri(input alu_op_t op, input reg_addr_t d, input reg_addr_t s1,
                         input logic a_pc, input word_t immv);
      send(1'b1, 1'b1, op, bru_beq, s1, 5'd0, d, 1'b1, a_pc, 1'b1, immv, '0);
   endtask

   task automatic bru(input bru_op_t op, input reg_addr_t d, input logic w,
                      input reg_addr_t s1, input reg_addr_t s2, input word_t off);
      send(1'b1, 1'b0, alu_add, op, s1, s2, d, w, 1'b0, 1'b0, '0, off);
   endtask

   task automatic alu_random();
      alu_rr(rand_alu_op(), 5'(1 + take_bits(4) % 15), rand_src(), rand_src());
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic end_test();
      int n;
      n = 0;
      idle();
      while (exp_cyc.size() != 0 && n < drain_limit) begin
         idle();
         n++;
      end
      if (exp_cyc.size() != 0) begin
         errors++;
         $display("pipeline did not drain in test %s", test_name);
         exp_cyc.delete();
         exp_commit.delete();
         exp_rd.delete();
         exp_data.delete();
         exp_pc.delete();
         exp_branch.delete();
         exp_target.delete();
      end
      repeat (4) idle();
      ntests++;
      $display("test %-16s %0d checks, %0d errors", test_name,
               checks - test_checks, errors - test_errors);
   endtask

   // outputs are sampled on the falling edge
   always @(negedge clk) begin
      cyc = cyc + 1;
      if (exp_cyc.size() != 0 && exp_cyc[0] == cyc) begin
         compare_flag("commit_vld", exp_commit[0], commit_vld);
         if (exp_commit[0]) begin
            compare_reg("commit_rd", exp_rd[0], commit_rd);
            compare_word("commit_data", exp_data[0], commit_data);
            compare_word("commit_pc", exp_pc[0], commit_pc);
         end
         compare_flag("branch", exp_branch[0], branch);
         if (exp_branch[0])
            compare_word("brn_addr", exp_target[0], brn_addr);
         void'(exp_cyc.pop_front());
         void'(exp_commit.pop_front());
         void'(exp_rd.pop_front());
         void'(exp_data.pop_front());
         void'(exp_pc.pop_front());
         void'(exp_branch.pop_front());
         void'(exp_target.pop_front());
      end else begin
         compare_flag("commit_vld", 1'b0, commit_vld);
         compare_flag("branch", 1'b0, branch);
      end
   end

   initial begin
      for (int i = 0; i < run_limit; i++)
         @(posedge clk);
      abort_run("run did not finish within the cycle limit");
   end

   initial begin
      bru_op_t   bop;
      reg_addr_t s;
      word_t     v;
      clk        = 1'b0;
      rst_n      = 1'b0;
      issue_vld  = 1'b0;
      issue_pc   = '0;
      rs1        = '0;
      rs2        = '0;
      rd         = '0;
      wen        = 1'b0;
      imm        = '0;
      alu_vld    = 1'b0;
      alu_op     = alu_add;
      alu_a_pc   = 1'b0;
      alu_b_imm  = 1'b0;
      bru_vld    = 1'b0;
      bru_op     = bru_beq;
      bru_offset = '0;
      lfsr       = 32'd91965;
      pc_next    = 32'h0000_1000;
      flush_cnt  = 0;
      checks     = 0;
      errors     = 0;
      ntests     = 0;
      for (int r = 0; r < 32; r++)
         shadow[r] = '0;

      // every register reads zero after reset
      start_test("reset");
      repeat (10) idle();
      rst_n <= 1'b1;
      for (int r = 0; r < reg_count; r++)
         alu_rr(alu_or, 5'd0, 5'(r), 5'(r));
      end_test();

      start_test("alu_random");
      for (int r = 1; r < 16; r++)
         alu_ri(alu_pass_b, 5'(r), 5'd0, 1'b0, take_bits(32));
      for (int op = 0; op < 12; op++)
         alu_rr(alu_op_t'(6'(op)), 5'(1 + op), rand_src(), rand_src());
      for (int k = 0; k < 200; k++) begin
         alu_random();
         repeat (take_bits(2)) idle();
      end
      end_test();

      start_test("operand_select");
      v = take_bits(32);
      alu_ri(alu_pass_b, 5'd5, 5'd0, 1'b0, v);
      alu_ri(alu_add, 5'd6, 5'd0, 1'b1, 32'h0000_0100);
      alu_ri(alu_add, 5'd7, 5'd5, 1'b0, 32'hffff_fff0);
      send(1'b1, 1'b1, alu_add, bru_beq, 5'd0, 5'd5, 5'd14, 1'b1, 1'b1, 1'b0, '0, '0);
      // r0 takes the commit but keeps reading zero
      alu_ri(alu_pass_b, 5'd0, 5'd0, 1'b0, take_bits(32));
      alu_rr(alu_or, 5'd10, 5'd0, 5'd0);
      alu_rr(alu_add, 5'd11, 5'd0, 5'd5);
      alu_rr(alu_add, 5'd12, 5'd5, 5'd0);
      idle();
      alu_rr(alu_or, 5'd13, 5'd0, 5'd0);
      end_test();

      // chains through M, W and write-through
      for (int d = 1; d <= 3; d++) begin
         start_test($sformatf("dependency_d%0d", d));
         for (int k = 0; k < 24; k++) begin
            s = (k >= d) ? 5'(8 + (k - d) % 4) : rand_src();
            alu_rr(rand_alu_op(), 5'(8 + k % 4), s, rand_src());
         end
         end_test();
      end

      start_test("branch_cond");
      for (int k = 0; k < 60; k++) begin
         s   = rand_src();
         bop = bru_op_t'(4'(take_bits(3) % 6));
         bru(bop, 5'd0, 1'b0, s, (take_bits(2) == 0) ? s : rand_src(), take_bits(32));
         alu_random();
         alu_random();
         alu_random();
         repeat (take_bits(1)) idle();
      end
      bru(bru_b, 5'd0, 1'b0, 5'd0, 5'd0, 32'h0000_0200);
      alu_random();
      alu_random();
      alu_random();
      alu_random();
      end_test();

      start_test("link_jirl");
      bru(bru_bl, 5'd20, 1'b1, 5'd0, 5'd0, 32'h0000_0040);
      alu_random();
      alu_random();
      alu_random();
      alu_rr(alu_add, 5'd21, 5'd20, 5'd0);
      alu_ri(alu_pass_b, 5'd22, 5'd0, 1'b0, 32'h0000_8000);
      bru(bru_jirl, 5'd23, 1'b1, 5'd22, 5'd0, 32'h0000_0010);
      alu_random();
      alu_random();
      alu_random();
      alu_rr(alu_add, 5'd24, 5'd23, 5'd20);
      for (int k = 0; k < 10; k++) begin
         alu_ri(alu_pass_b, 5'd25, 5'd0, 1'b0, take_bits(32));
         repeat (take_bits(2)) idle();
         bru(bru_jirl, 5'd26, 1'b1, 5'd25, 5'd0, take_bits(32));
         alu_random();
         alu_random();
         alu_random();
         alu_rr(alu_xor, 5'd27, 5'd26, 5'd25);
      end
      end_test();

      $display("tests: %0d, checks: %0d, errors: %0d", ntests, checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== vlog.f ====
source/exu_pkg.sv
source/exu_regfile.sv
source/exu_bypass.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_pipe.sv
source/exu_top.sv
sim/exu_tb.sv
